// ==== hw/sram_alloc_macros.svh ====
`ifndef SRAM_ALLOC_MACROS_SVH
`define SRAM_ALLOC_MACROS_SVH

// Shared SRAM bank pool
`define SA_BANKS 32
`define SA_PORTS 16

// Free space per bank, in words
`define SA_SPACE_W 11
`define SA_BANK_SPACE 2047

// Packet length limits
`define SA_LEN_W 9
`define SA_MAX_LEN 288

// Packets of one port held in one bank
`define SA_CNT_W 9

`endif

// ==== hw/sram_alloc_pkg.sv ====
`include "sram_alloc_macros.svh"

package sram_alloc_pkg;

    typedef enum logic [1:0] {
        MODE_STATIC  = 2'd0, // Home bank only
        MODE_SEMI    = 2'd1, // Home bank, then 16 to 31
        MODE_DYNAMIC = 2'd2  // All banks
    } match_mode_e;

    typedef struct packed {
        logic [3:0]           dest_port;
        logic [`SA_LEN_W-1:0] length;
        logic [2:0]           rsvd;
    } pkt_header_s;

    typedef struct packed {
        logic       ok;
        logic [4:0] bank;
    } alloc_result_s;

    // Longest scan of each mode, in bank visits
    function automatic logic [5:0] max_visits(match_mode_e mode);
        case (mode)
            MODE_STATIC: return 6'd1;
            MODE_SEMI:   return 6'd17;
            default:     return 6'd32;
        endcase
    endfunction

endpackage

// ==== hw/match_req_if.sv ====
`include "sram_alloc_macros.svh"

interface match_req_if;

    logic                        start;
    logic [3:0]                  dest_port;
    logic [`SA_LEN_W-1:0]        length;
    sram_alloc_pkg::match_mode_e mode;
    logic [5:0]                  threshold; // Already clamped to 1..max
    logic                        done;
    sram_alloc_pkg::alloc_result_s result;

    modport decode (
        output start, dest_port, length, mode, threshold,
        input  done, result
    );

    modport execute (
        input  start, dest_port, length, mode, threshold,
        output done, result
    );

    modport commit (
        input done, result, dest_port, length
    );

endinterface

// ==== hw/bank_probe_if.sv ====
`include "sram_alloc_macros.svh"

interface bank_probe_if;

    logic [4:0]             probe_bank;
    logic [3:0]             probe_port;
    logic [`SA_SPACE_W-1:0] free_space;
    logic                   busy;
    logic [`SA_CNT_W-1:0]   packet_amount;

    modport scan (
        output probe_bank, probe_port,
        input  free_space, busy, packet_amount
    );

    modport serve (
        input  probe_bank, probe_port,
        output free_space, busy, packet_amount
    );

endinterface

// ==== hw/alloc_request_decoder.sv ====
`include "sram_alloc_macros.svh"

module alloc_request_decoder (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    input  sram_alloc_pkg::pkt_header_s req_header,
    input  logic [1:0]                  match_mode,
    input  logic [4:0]                  threshold,
    output logic                        busy,
    output logic                        alloc_done,
    output logic                        alloc_ok,
    output logic [4:0]                  alloc_bank,
    match_req_if.decode                 mreq
);

    logic                        accept;
    logic                        legal;
    sram_alloc_pkg::match_mode_e mode_in;
    logic [5:0]                  max_vis;
    logic [5:0]                  thr_eff;
    logic                        rej_q;    // Illegal length seen last cycle
    logic                        rej_done;

    assign accept = req_valid && !busy;
    assign legal  = (req_header.length != '0) && (req_header.length <= `SA_MAX_LEN);

    always_comb begin
        if (match_mode == 2'd3) begin
            mode_in = sram_alloc_pkg::MODE_DYNAMIC; // Code 3 behaves as dynamic
        end else begin
            mode_in = sram_alloc_pkg::match_mode_e'(match_mode);
        end
        max_vis = sram_alloc_pkg::max_visits(mode_in);
    end

    always_comb begin
        if (threshold == 5'd0) begin
            thr_eff = 6'd1;
        end else if ({1'b0, threshold} > max_vis) begin
            thr_eff = max_vis;
        end else begin
            thr_eff = {1'b0, threshold};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            mreq.start <= 1'b0;
            rej_q      <= 1'b0;
            rej_done   <= 1'b0;
        end else begin
            mreq.start <= accept && legal;
            rej_q      <= accept && !legal;
            rej_done   <= rej_q;
            if (accept) begin
                busy <= 1'b1;
            end else if (alloc_done) begin
                busy <= 1'b0; // Free again one cycle after done
            end
        end
    end

    // Held stable for the matcher until done
    always_ff @(posedge clk) begin
        if (accept) begin
            mreq.dest_port <= req_header.dest_port;
            mreq.length    <= req_header.length;
            mreq.mode      <= mode_in;
            mreq.threshold <= thr_eff;
        end
    end

    assign alloc_done = rej_done | mreq.done;
    assign alloc_ok   = mreq.done & mreq.result.ok;
    assign alloc_bank = mreq.result.bank;

endmodule

// ==== hw/port_sram_matcher.sv ====
`include "sram_alloc_macros.svh"

module port_sram_matcher #(
    parameter int PORT_IDX = 0
) (
    input  logic        clk,
    input  logic        rst_n,
    match_req_if.execute mreq,
    bank_probe_if.scan   probe
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SCAN,
        S_FINISH
    } state_e;

    state_e               state;
    logic                 prev_valid;
    logic [3:0]           prev_dest;
    logic [4:0]           prev_bank;
    logic [5:0]           visited;
    logic [5:0]           visited_n;
    logic [5:0]           max_vis;
    logic                 found;
    logic                 found_n;
    logic [4:0]           best;
    logic [4:0]           best_n;
    logic [`SA_CNT_W-1:0] best_amt;
    logic                 fits;
    logic                 cand;
    logic                 upd;
    logic                 hit;
    logic                 end_ok;
    logic                 end_fail;

    // Bank visited at position idx of the mode's scan order
    function automatic logic [4:0] bank_of(sram_alloc_pkg::match_mode_e mode,
                                           logic [5:0] idx);
        logic [5:0] upper;
        upper = idx + 6'd15;
        case (mode)
            sram_alloc_pkg::MODE_STATIC: return PORT_IDX[4:0];
            sram_alloc_pkg::MODE_SEMI:   return (idx == 6'd0) ? PORT_IDX[4:0] : upper[4:0];
            default:                     return idx[4:0];
        endcase
    endfunction

    assign probe.probe_port = mreq.dest_port;

    always_comb begin
        max_vis   = sram_alloc_pkg::max_visits(mreq.mode);
        fits      = probe.free_space >= {2'b00, mreq.length};
        cand      = fits && !probe.busy;
        upd       = cand && (!found || probe.packet_amount > best_amt); // Ties keep earlier
        found_n   = found | cand;
        best_n    = upd ? probe.probe_bank : best;
        visited_n = visited + 6'd1;
        // Probe points at prev_bank while idle
        hit       = prev_valid && (mreq.dest_port == prev_dest) && fits;
        end_ok    = (visited_n >= mreq.threshold) && found_n;
        end_fail  = visited_n == max_vis;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            mreq.done   <= 1'b0;
            mreq.result <= '0;
            prev_valid  <= 1'b0;
        end else begin
            mreq.done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (mreq.start) begin
                        state <= hit ? S_FINISH : S_SCAN;
                    end
                end
                S_SCAN: begin
                    if (end_ok || end_fail) begin
                        state <= S_FINISH;
                    end
                end
                S_FINISH: begin
                    mreq.done        <= 1'b1;
                    mreq.result.ok   <= found;
                    mreq.result.bank <= best;
                    prev_valid       <= found; // A failed request turns the fast path off
                    state            <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                visited    <= 6'd0;
                best_amt   <= '0;
                probe_bank_sel();
                if (mreq.start) begin
                    found <= hit;
                    best  <= prev_bank;
                end
            end
            S_SCAN: begin
                found            <= found_n;
                best             <= best_n;
                visited          <= visited_n;
                probe.probe_bank <= bank_of(mreq.mode, visited_n); // Next bank in order
                if (upd) begin
                    best_amt <= probe.packet_amount;
                end
            end
            default: begin
                prev_dest        <= mreq.dest_port;
                prev_bank        <= best;
                probe.probe_bank <= best;
            end
        endcase
    end

    // Idle probe selection, first scan bank on a miss
    task automatic probe_bank_sel();
        if (mreq.start && !hit) begin
            probe.probe_bank <= bank_of(mreq.mode, 6'd0);
        end else begin
            probe.probe_bank <= prev_bank;
        end
    endtask

endmodule

// ==== hw/bank_state_table.sv ====
`include "sram_alloc_macros.svh"

module bank_state_table (
    input  logic                 clk,
    input  logic                 rst_n,
    match_req_if.commit          mreq,
    bank_probe_if.serve          probe,
    input  logic [31:0]          bank_busy,
    input  logic                 release_valid,
    input  logic [4:0]           release_bank,
    input  logic [3:0]           release_port,
    input  logic [8:0]           release_length
);

    logic [`SA_SPACE_W-1:0] free_space [`SA_BANKS];
    logic [`SA_CNT_W-1:0]   pkt_cnt    [`SA_BANKS][`SA_PORTS];

    logic                 rel_q;
    logic [4:0]           rel_bank_q;
    logic [3:0]           rel_port_q;
    logic [`SA_LEN_W-1:0] rel_len_q;
    logic                 commit;

    assign commit = mreq.done && mreq.result.ok;

    // Release lands one cycle after its strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rel_q <= 1'b0;
        end else begin
            rel_q <= release_valid;
        end
    end

    always_ff @(posedge clk) begin
        rel_bank_q <= release_bank;
        rel_port_q <= release_port;
        rel_len_q  <= release_length;
    end

    always_ff @(posedge clk) begin : upd_blk
        logic [`SA_SPACE_W:0]   sum;
        logic [`SA_SPACE_W-1:0] add_w;
        logic [`SA_SPACE_W-1:0] sub_w;
        logic                   rel_hit;
        logic                   com_hit;
        logic                   inc;
        logic                   dec;
        if (!rst_n) begin
            for (int b = 0; b < `SA_BANKS; b++) begin
                free_space[b] <= `SA_SPACE_W'(`SA_BANK_SPACE);
                for (int p = 0; p < `SA_PORTS; p++) begin
                    pkt_cnt[b][p] <= '0;
                end
            end
        end else begin
            for (int b = 0; b < `SA_BANKS; b++) begin
                rel_hit = rel_q && (rel_bank_q == 5'(b));
                com_hit = commit && (mreq.result.bank == 5'(b));
                add_w   = rel_hit ? {2'b00, rel_len_q} : '0;
                sub_w   = com_hit ? {2'b00, mreq.length} : '0;
                sum     = {1'b0, free_space[b]} + {1'b0, add_w} - {1'b0, sub_w};
                if (sum > `SA_BANK_SPACE) begin
                    free_space[b] <= `SA_SPACE_W'(`SA_BANK_SPACE); // Saturate at capacity
                end else begin
                    free_space[b] <= sum[`SA_SPACE_W-1:0];
                end
                for (int p = 0; p < `SA_PORTS; p++) begin
                    inc = com_hit && (mreq.dest_port == 4'(p));
                    dec = rel_hit && (rel_port_q == 4'(p));
                    if (inc && !dec && (pkt_cnt[b][p] != '1)) begin
                        pkt_cnt[b][p] <= pkt_cnt[b][p] + 1'b1;
                    end else if (dec && !inc && (pkt_cnt[b][p] != '0)) begin
                        pkt_cnt[b][p] <= pkt_cnt[b][p] - 1'b1;
                    end
                end
            end
        end
    end

    // Combinational answer for the matcher
    assign probe.free_space    = free_space[probe.probe_bank];
    assign probe.busy          = bank_busy[probe.probe_bank];
    assign probe.packet_amount = pkt_cnt[probe.probe_bank][probe.probe_port];

endmodule

// ==== hw/sram_alloc_top.sv ====
`include "sram_alloc_macros.svh"

module sram_alloc_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    input  sram_alloc_pkg::pkt_header_s req_header,
    input  logic [1:0]                  match_mode,
    input  logic [4:0]                  threshold,
    input  logic [`SA_BANKS-1:0]        bank_busy,
    input  logic                        release_valid,
    input  logic [4:0]                  release_bank,
    input  logic [3:0]                  release_port,
    input  logic [`SA_LEN_W-1:0]        release_length,
    output logic                        busy,
    output logic                        alloc_done,
    output logic                        alloc_ok,
    output logic [4:0]                  alloc_bank
);

    match_req_if  u_mreq ();
    bank_probe_if u_probe ();

    alloc_request_decoder u_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_header (req_header),
        .match_mode (match_mode),
        .threshold  (threshold),
        .busy       (busy),
        .alloc_done (alloc_done),
        .alloc_ok   (alloc_ok),
        .alloc_bank (alloc_bank),
        .mreq       (u_mreq.decode)
    );

    port_sram_matcher #(
        .PORT_IDX (0) // Home bank of this ingress port
    ) u_matcher (
        .clk   (clk),
        .rst_n (rst_n),
        .mreq  (u_mreq.execute),
        .probe (u_probe.scan)
    );

    bank_state_table u_table (
        .clk            (clk),
        .rst_n          (rst_n),
        .mreq           (u_mreq.commit),
        .probe          (u_probe.serve),
        .bank_busy      (bank_busy),
        .release_valid  (release_valid),
        .release_bank   (release_bank),
        .release_port   (release_port),
        .release_length (release_length)
    );

endmodule

// ==== sim/sram_alloc_assert.sv ====
module sram_alloc_assert (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic alloc_done,
    input logic start,
    input logic done
);
    timeunit 1ns;
    timeprecision 100ps;

    logic in_flight; // Matcher holds a request
    int   assert_fails = 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
        end else if (start) begin
            in_flight <= 1'b1;
        end else if (done) begin
            in_flight <= 1'b0;
        end
    end

    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_done |=> !alloc_done)
    else begin
        assert_fails++;
        $error("alloc_done held for more than one cycle");
    end

    done_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_done |-> busy)
    else begin
        assert_fails++;
        $error("alloc_done while busy is low");
    end

    no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !in_flight)
    else begin
        assert_fails++;
        $error("start pulsed again before done");
    end

endmodule

// ==== sim/sram_alloc_tb.sv ====
`include "sram_alloc_macros.svh"

module sram_alloc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 200;

    logic                        clk;
    logic                        rst_n;
    logic                        req_valid;
    sram_alloc_pkg::pkt_header_s req_header;
    logic [1:0]                  match_mode;
    logic [4:0]                  threshold;
    logic [`SA_BANKS-1:0]        bank_busy;
    logic                        release_valid;
    logic [4:0]                  release_bank;
    logic [3:0]                  release_port;
    logic [`SA_LEN_W-1:0]        release_length;
    logic                        busy;
    logic                        alloc_done;
    logic                        alloc_ok;
    logic [4:0]                  alloc_bank;

    int         m_free [`SA_BANKS];
    int         m_cnt  [`SA_BANKS][`SA_PORTS];
    bit         m_prev_valid;
    int         m_prev_dest;
    int         m_prev_bank;
    logic [5:0] exp_q [$]; // {ok, bank} per pending request
    int         pk_bank [$];
    int         pk_port [$];
    int         pk_len [$];
    int         errors = 0;
    int         checks = 0;
    logic [31:0] rng;

    sram_alloc_top u_sram_alloc_top (.*);

    bind sram_alloc_top sram_alloc_assert u_sram_alloc_assert (
        .clk        (clk),
        .rst_n      (rst_n),
        .busy       (busy),
        .alloc_done (alloc_done),
        .start      (u_mreq.start),
        .done       (u_mreq.done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Returns {fast path, ok, bank}
    function automatic logic [6:0] expected_alloc(int dest, int len, int mode, int thr,
                                                  logic [31:0] mask);
        int  visits;
        int  limit;
        int  bank;
        int  best;
        bit  found;
        if (len < 1 || len > `SA_MAX_LEN) return 7'd0;
        if (m_prev_valid && dest == m_prev_dest && m_free[m_prev_bank] >= len)
            return {2'b11, 5'(m_prev_bank)};
        visits = (mode == 0) ? 1 : (mode == 1) ? 17 : 32;
        limit  = (thr < 1) ? 1 : (thr > visits) ? visits : thr;
        found  = 1'b0;
        best   = 0;
        for (int i = 0; i < visits; i++) begin
            bank = (mode == 0) ? 0 : (mode == 1) ? ((i == 0) ? 0 : i + 15) : i;
            if (m_free[bank] >= len && !mask[bank] &&
                (!found || m_cnt[bank][dest] > m_cnt[best][dest])) begin
                found = 1'b1;
                best  = bank;
            end
            if (found && i + 1 >= limit) break;
        end
        return {1'b0, found, 5'(best)};
    endfunction

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 u_sram_alloc_top.u_sram_alloc_assert.assert_fails);
        if (errors == 0 && u_sram_alloc_top.u_sram_alloc_assert.assert_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(string what);
        $display("TIMEOUT at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic run_request(int dest, int len, int mode, int thr, logic [31:0] mask,
                               bit extra);
        logic [6:0] exp;
        bit         legal;
        int         n;
        exp   = expected_alloc(dest, len, mode, thr, mask);
        legal = len >= 1 && len <= `SA_MAX_LEN;
        exp_q.push_back(exp[5:0]);
        if (exp[5]) begin
            m_free[exp[4:0]] -= len;
            m_cnt[exp[4:0]][dest] += 1;
            pk_bank.push_back(exp[4:0]);
            pk_port.push_back(dest);
            pk_len.push_back(len);
        end
        if (legal) begin
            m_prev_valid = exp[5];
            m_prev_dest  = dest;
            m_prev_bank  = exp[4:0];
        end
        req_header = {4'(dest), 9'(len), 3'd0};
        match_mode = 2'(mode);
        threshold  = 5'(thr);
        bank_busy  = mask;
        req_valid  = 1'b1;
        @(negedge clk);
        req_valid = extra; // Second strobe lands while busy
        checks++;
        if (busy !== 1'b1) begin
            $display("MISMATCH at %0t: busy not raised after req_valid", $time);
            errors++;
        end
        n = 1;
        while (!alloc_done && n < TIMEOUT) begin
            @(negedge clk);
            req_valid = 1'b0;
            n++;
        end
        checks++;
        if (!alloc_done) begin
            report_timeout("no alloc_done for a request");
        end else if ((exp[6] && n != 3) || (!legal && n != 2)) begin
            $display("MISMATCH at %0t: alloc_done after %0d cycles", $time, n);
            errors++;
        end
        @(negedge clk);
        checks++;
        if (busy !== 1'b0) begin
            $display("MISMATCH at %0t: busy still high one cycle after alloc_done", $time);
            errors++;
        end
        n = 0;
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy) report_timeout("busy stayed high after alloc_done");
    endtask

    task automatic release_packet(int idx);
        int b;
        b              = pk_bank[idx];
        release_bank   = 5'(b);
        release_port   = 4'(pk_port[idx]);
        release_length = 9'(pk_len[idx]);
        release_valid  = 1'b1;
        m_free[b]      = m_free[b] + pk_len[idx];
        if (m_free[b] > `SA_BANK_SPACE) m_free[b] = `SA_BANK_SPACE;
        if (m_cnt[b][pk_port[idx]] > 0) m_cnt[b][pk_port[idx]] -= 1;
        pk_bank.delete(idx);
        pk_port.delete(idx);
        pk_len.delete(idx);
        @(negedge clk);
        release_valid = 1'b0;
        @(negedge clk);
        @(negedge clk); // Applied one cycle after the strobe
    endtask

    always @(negedge clk) begin : compare_blk
        logic [5:0] exp;
        if (rst_n && alloc_done) begin
            if (exp_q.size() == 0) begin
                $display("alloc_done at %0t without a pending request", $time);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                checks++;
                if (alloc_ok !== exp[5] || (exp[5] && alloc_bank !== exp[4:0])) begin
                    $display("MISMATCH at %0t: ok %0b bank %0d, expected ok %0b bank %0d",
                             $time, alloc_ok, alloc_bank, exp[5], exp[4:0]);
                    errors++;
                end
            end
        end
    end

    initial begin : main_blk
        logic [31:0] r;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_header = '0;
        match_mode = 2'd0;
        threshold = 5'd1;
        bank_busy = '0;
        release_valid = 1'b0;
        release_bank = '0;
        release_port = '0;
        release_length = '0;
        m_prev_valid = 1'b0;
        rng = 32'd86818;
        for (int b = 0; b < `SA_BANKS; b++) begin
            m_free[b] = `SA_BANK_SPACE;
            for (int p = 0; p < `SA_PORTS; p++) m_cnt[b][p] = 0;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < 8; i++) run_request(3, 288, 0, 1, '0, 1'b0); // Fill bank 0
        run_request(5, 16, 0, 1, 32'h1, 1'b0);
        release_packet(0);
        run_request(3, 288, 0, 1, '0, 1'b0);
        run_request(5, 16, 0, 1, '0, 1'b0);
        run_request(2, 0, 2, 4, '0, 1'b0);
        run_request(2, 289, 1, 4, '0, 1'b0);
        run_request(4, 100, 2, 5, '0, 1'b1);
        run_request(4, 0, 2, 5, '0, 1'b1);
        run_request(4, 100, 2, 5, '0, 1'b0); // Fast path survives a rejected header
        for (int i = 0; i < 12; i++) run_request(7, 200, 2, 32, '0, 1'b0);
        for (int i = 0; i < 80; i++) begin
            rng = xorshift32(rng);
            if (rng[2:0] == 3'd0 && pk_bank.size() > 0) begin
                release_packet(int'(rng[31:8]) % pk_bank.size());
            end
            rng = xorshift32(rng);
            r   = rng;
            rng = xorshift32(rng);
            run_request(int'(r[1:0]), int'(r[10:2]) % `SA_MAX_LEN + 1,
                        1 + int'(r[12:11]) % 3, int'(r[17:13]),
                        rng & {rng[15:0], rng[31:16]}, 1'b0);
        end
        repeat (10) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d requests ended without alloc_done", exp_q.size());
            errors++;
        end
        finish_run();
    end

endmodule

// ==== all.f ====
+incdir+hw
hw/sram_alloc_pkg.sv
hw/match_req_if.sv
hw/bank_probe_if.sv
hw/alloc_request_decoder.sv
hw/port_sram_matcher.sv
hw/bank_state_table.sv
hw/sram_alloc_top.sv
sim/sram_alloc_assert.sv
sim/sram_alloc_tb.sv
